/* build.f */
+incdir+logic
logic/lookup_pkg.sv
logic/entry_index_counter.sv
logic/key_match_table.sv
logic/action_table.sv
logic/table_config_parser.sv
logic/lookup_sequencer.sv
logic/lookup_engine.sv
test/lookup_engine_tb.sv

/* Makefile */
# Verilator build and run for the lookup stage testbench

VERILATOR ?= verilator
TOP       ?= lookup_engine_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh test/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/lookup_engine_tb.sv */
//####################
// lookup stage testbench
// random table writes, forwarded packets
// and lookups against a table model
//####################

`timescale 1ns/1ns

`include "lookup_macros.svh"

module lookup_engine_tb;

    localparam logic [4:0] STAGE = 5'd3;
    localparam logic [2:0] LOOKUP = 3'd2;
    // roughly 4000 cycles of traffic
    localparam int unsigned MAX_CYCLES = 20000;

    logic clk = 1'b0;
    logic rst_n;
    logic key_valid;
    logic action_valid;
    lookup_pkg::lookup_key_t    key_in;
    lookup_pkg::lookup_result_t result;
    lookup_pkg::ctrl_beat_t     ctrl_in;
    lookup_pkg::ctrl_beat_t     ctrl_out;

    // table model
    logic [`LOOKUP_KEY_W-1:0] model_key [`LOOKUP_DEPTH];
    logic                     model_valid [`LOOKUP_DEPTH];
    logic [`LOOKUP_ACT_W-1:0] model_act [`LOOKUP_DEPTH];

    logic [`CTRL_DATA_W-1:0] pkt_words [$];
    int unsigned error_count = 0;
    int unsigned cycle_count = 0;

    lookup_engine #(
        .STAGE_ID  (STAGE),
        .LOOKUP_ID (LOOKUP)
    ) lookup_engine_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_in       (key_in),
        .key_valid    (key_valid),
        .result       (result),
        .action_valid (action_valid),
        .ctrl_in      (ctrl_in),
        .ctrl_out     (ctrl_out)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $fatal(1, "simulation timeout");
        end
    end

    task automatic compare_value(input logic [127:0] actual, input logic [127:0] expected,
                                 input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
            $display("Test failures found");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [63:0] make_header(input logic [4:0] stage, input logic [2:0] lid,
                                                input logic [3:0] sel, input logic [15:0] flag,
                                                input logic [3:0] index);
        logic [63:0] hdr;
        hdr = '0;
        hdr[`HDR_MODID_LSB +: 8] = {stage, lid};
        hdr[`HDR_RESV_LSB +: 4]  = sel;
        hdr[`HDR_FLAG_LSB +: 16] = flag;
        hdr[`HDR_INDEX_LSB +: 8] = {4'd0, index};
        return hdr;
    endfunction

    // lowest valid entry whose unmasked bits agree
    function automatic void model_lookup(input logic [31:0] key, input logic [31:0] mask,
                                         output logic hit, output logic [47:0] act);
        hit = 1'b0;
        act = `DEFAULT_ACTION;
        for (int i = 0; i < `LOOKUP_DEPTH; i++) begin
            if (!hit && model_valid[i] && ((model_key[i] & ~mask) == (key & ~mask))) begin
                hit = 1'b1;
                act = model_act[i];
            end
        end
    endfunction

    function automatic logic [31:0] random_mask();
        case ($urandom_range(3, 0))
            0: return '0;
            1: return $urandom() & $urandom() & $urandom();
            2: return $urandom() | $urandom() | $urandom();
            default: return $urandom();
        endcase
    endfunction

    task automatic expect_ctrl_out(input logic exp_valid, input logic [64:0] exp_beat);
        compare_value(128'(ctrl_out.valid), 128'(exp_valid), "ctrl_out valid");
        if (exp_valid) begin
            compare_value(128'({ctrl_out.data, ctrl_out.last}), 128'(exp_beat), "ctrl_out beat");
        end
    endtask

    // drives pkt_words and checks ctrl_out one cycle behind
    task automatic send_packet(input logic consumed);
        logic [64:0] prev;
        logic        have_prev;
        have_prev = 1'b0;
        prev      = '0;
        for (int i = 0; i < int'(pkt_words.size()); i++) begin
            @(negedge clk);
            expect_ctrl_out(have_prev && !consumed, prev);
            ctrl_in.data  = pkt_words[i];
            ctrl_in.last  = (i == int'(pkt_words.size()) - 1);
            ctrl_in.valid = 1'b1;
            prev      = {ctrl_in.data, ctrl_in.last};
            have_prev = 1'b1;
        end
        @(negedge clk);
        expect_ctrl_out(!consumed, prev);
        ctrl_in = '0;
        @(negedge clk);
        expect_ctrl_out(1'b0, prev);
    endtask

    task automatic write_table(input logic is_key, input logic [3:0] start, input int count);
        logic [63:0] entry;
        logic [3:0]  sel;
        logic [3:0]  pos;
        logic [3:0]  pick;
        sel = is_key ? 4'd0 : 4'(1 + $urandom_range(14, 0));
        pkt_words.delete();
        pkt_words.push_back(make_header(STAGE, LOOKUP, sel, `CTRL_FLAG, start));
        pos = start;
        for (int j = 0; j < count; j++) begin
            entry = {$urandom(), $urandom()};
            pick  = 4'($urandom());
            // duplicate keys exercise the priority order
            if (is_key && model_valid[pick] && $urandom_range(2, 0) == 0) begin
                entry[31:0] = model_key[pick];
            end
            pkt_words.push_back(entry);
            if (is_key) begin
                model_key[pos]   = entry[31:0];
                model_valid[pos] = 1'b1;
            end else begin
                model_act[pos] = entry[47:0];
            end
            pos = pos + 4'd1;
        end
        send_packet(1'b1);
    endtask

    task automatic forward_packet();
        logic [4:0]  stage;
        logic [2:0]  lid;
        logic [15:0] flag;
        int unsigned kind;
        int unsigned len;
        stage = STAGE;
        lid   = LOOKUP;
        flag  = `CTRL_FLAG;
        kind  = $urandom_range(2, 0);
        if (kind == 0) begin
            stage = STAGE ^ 5'($urandom_range(31, 1));
        end else if (kind == 1) begin
            lid = LOOKUP ^ 3'($urandom_range(7, 1));
        end else begin
            flag = `CTRL_FLAG ^ 16'($urandom_range(65535, 1));
        end
        len = $urandom_range(5, 1);
        pkt_words.delete();
        pkt_words.push_back(make_header(stage, lid, 4'($urandom()), flag, 4'($urandom())));
        for (int unsigned j = 1; j < len; j++) begin
            pkt_words.push_back({$urandom(), $urandom()});
        end
        send_packet(1'b0);
    endtask

    // extra holds key_valid high while the lookup is busy
    task automatic run_lookup(input logic [31:0] key, input logic [31:0] mask,
                              input logic [63:0] phv, input logic extra);
        logic        hit;
        logic [47:0] exp_act;
        int unsigned lat;
        model_lookup(key, mask, hit, exp_act);
        @(negedge clk);
        key_in.key  = key;
        key_in.mask = mask;
        key_in.phv  = phv;
        key_valid   = 1'b1;
        @(posedge clk);
        @(negedge clk);
        key_valid = extra;
        if (extra) begin
            key_in.key  = $urandom();
            key_in.mask = '0;
            key_in.phv  = {$urandom(), $urandom()};
        end
        lat = 0;
        while (!action_valid) begin
            @(posedge clk);
            lat++;
            @(negedge clk);
            key_valid = extra && !action_valid;
        end
        compare_value(128'(lat), hit ? 128'(3) : 128'(2), "result latency");
        compare_value(128'({result.action, result.phv}), 128'({exp_act, phv}), "lookup result");
        repeat (extra ? 6 : 1) begin
            @(negedge clk);
            compare_value(128'(action_valid), 128'(0), "unexpected action_valid");
        end
    endtask

    task automatic random_lookups(input int unsigned count, input logic extra);
        logic [3:0]  pick;
        logic [31:0] key;
        logic [31:0] mask;
        for (int unsigned n = 0; n < count; n++) begin
            mask = random_mask();
            pick = 4'($urandom());
            if ($urandom_range(2, 0) != 0 && model_valid[pick]) begin
                key = model_key[pick] ^ ($urandom() & mask);
            end else begin
                key = $urandom();
            end
            run_lookup(key, mask, {$urandom(), $urandom()}, extra);
        end
    endtask

    initial begin
        void'($urandom(32'h6606));
        rst_n     = 1'b0;
        key_in    = '0;
        key_valid = 1'b0;
        ctrl_in   = '0;
        for (int i = 0; i < `LOOKUP_DEPTH; i++) begin
            model_valid[i] = 1'b0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // empty table after reset
        compare_value(128'(action_valid), 128'(0), "action_valid after reset");
        compare_value(128'(ctrl_out.valid), 128'(0), "ctrl_out valid after reset");
        run_lookup($urandom(), random_mask(), {$urandom(), $urandom()}, 1'b0);

        // fill the action table and part of the key table
        write_table(1'b0, 4'($urandom()), 16);
        write_table(1'b1, 4'($urandom()), 6);
        write_table(1'b1, 4'($urandom()), 5);
        random_lookups(200, 1'b0);

        // foreign packets pass through and a header-only write is dropped
        repeat (30) forward_packet();
        pkt_words.delete();
        pkt_words.push_back(make_header(STAGE, LOOKUP, 4'd0, `CTRL_FLAG, 4'($urandom())));
        send_packet(1'b1);
        random_lookups(40, 1'b0);

        random_lookups(20, 1'b1);

        // overwrite entries including index 0
        write_table(1'b1, 4'($urandom()), 4);
        write_table(1'b0, 4'($urandom()), 3);
        write_table(1'b1, 4'd0, 2);
        random_lookups(150, 1'b0);

        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* logic/lookup_engine.sv */
//####################
// match-action lookup stage
// key lookup path plus control path
// that writes the key and action tables
//####################

`timescale 1ns/1ns

`include "lookup_macros.svh"

module lookup_engine #(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] LOOKUP_ID = 3'd0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  lookup_pkg::lookup_key_t    key_in,
    input  logic                       key_valid,
    output lookup_pkg::lookup_result_t result,
    output logic                       action_valid,
    input  lookup_pkg::ctrl_beat_t     ctrl_in,
    output lookup_pkg::ctrl_beat_t     ctrl_out
);

    lookup_pkg::table_write_t wr;

    logic                     idx_load;
    logic                     idx_advance;
    logic [`LOOKUP_IDX_W-1:0] idx_load_value;
    logic [`LOOKUP_IDX_W-1:0] idx;

    logic                     match;
    logic [`LOOKUP_IDX_W-1:0] match_index;
    logic                     rd_en;
    logic [`LOOKUP_IDX_W-1:0] rd_index;
    logic [`LOOKUP_ACT_W-1:0] rd_action;

    // control path
    table_config_parser #(
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) table_config_parser_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_in        (ctrl_in),
        .ctrl_out       (ctrl_out),
        .wr             (wr),
        .idx_load       (idx_load),
        .idx_load_value (idx_load_value),
        .idx_advance    (idx_advance),
        .idx            (idx)
    );

    entry_index_counter entry_index_counter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (idx_load),
        .load_value (idx_load_value),
        .advance    (idx_advance),
        .idx        (idx)
    );

    // lookup path
    key_match_table key_match_table_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (wr),
        .key_in      (key_in),
        .match       (match),
        .match_index (match_index)
    );

    action_table action_table_i (
        .clk       (clk),
        .wr        (wr),
        .rd_en     (rd_en),
        .rd_index  (rd_index),
        .rd_action (rd_action)
    );

    lookup_sequencer lookup_sequencer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .phv_in       (key_in.phv),
        .match        (match),
        .match_index  (match_index),
        .rd_en        (rd_en),
        .rd_index     (rd_index),
        .rd_action    (rd_action),
        .result       (result),
        .action_valid (action_valid)
    );

endmodule

/* logic/lookup_sequencer.sv */
//####################
// lookup sequencer
// waits for the key compare, reads the
// action on a hit and sends the result
//####################

`timescale 1ns/1ns

`include "lookup_macros.svh"

module lookup_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       key_valid,
    input  logic [`LOOKUP_PHV_W-1:0]   phv_in,
    input  logic                       match,
    input  logic [`LOOKUP_IDX_W-1:0]   match_index,
    output logic                       rd_en,
    output logic [`LOOKUP_IDX_W-1:0]   rd_index,
    input  logic [`LOOKUP_ACT_W-1:0]   rd_action,
    output lookup_pkg::lookup_result_t result,
    output logic                       action_valid
);

    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        READ,
        SEND
    } state_e;

    state_e state_q;

    logic [`LOOKUP_PHV_W-1:0] phv_q;

    // match is settled once the sequencer reaches READ
    assign rd_en    = (state_q == READ) && match;
    assign rd_index = match_index;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            action_valid <= 1'b0;
        end else begin
            action_valid <= 1'b0;
            case (state_q)
                IDLE: begin
                    // strobes in any other state are dropped
                    if (key_valid) begin
                        state_q <= CHECK;
                    end
                end
                CHECK: begin
                    state_q <= READ;
                end
                READ: begin
                    if (match) begin
                        state_q <= SEND;
                    end else begin
                        action_valid <= 1'b1;
                        state_q      <= IDLE;
                    end
                end
                default: begin
                    action_valid <= 1'b1;
                    state_q      <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && key_valid) begin
            phv_q <= phv_in;
        end
        if (state_q == READ && !match) begin
            result <= '{action: `DEFAULT_ACTION, phv: phv_q};
        end else if (state_q == SEND) begin
            result <= '{action: rd_action, phv: phv_q};
        end
    end

    a_valid_pulse : assert property (
        @(posedge clk) disable iff (!rst_n) action_valid |=> !action_valid
    ) else $error("action_valid held for two cycles");

endmodule

/* logic/table_config_parser.sv */
//####################
// control stream parser
// consumes table write packets for this
// stage and forwards everything else
//####################

`timescale 1ns/1ns

`include "lookup_macros.svh"

module table_config_parser #(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] LOOKUP_ID = 3'd0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  lookup_pkg::ctrl_beat_t    ctrl_in,
    output lookup_pkg::ctrl_beat_t    ctrl_out,
    output lookup_pkg::table_write_t  wr,
    output logic                      idx_load,
    output logic [`LOOKUP_IDX_W-1:0]  idx_load_value,
    output logic                      idx_advance,
    input  logic [`LOOKUP_IDX_W-1:0]  idx
);

    typedef enum logic [1:0] {
        IDLE,
        KEY_ENTRY,
        ACT_ENTRY,
        FORWARD
    } state_e;

    state_e state_q;
    state_e state_d;

    logic [7:0]  hdr_mod_id;
    logic [3:0]  hdr_sel;
    logic [15:0] hdr_flag;
    logic        hdr_hit;
    logic        fwd;

    logic                     out_valid_q;
    logic                     out_last_q;
    logic [`CTRL_DATA_W-1:0]  out_data_q;
    logic                     key_we_q;
    logic                     act_we_q;
    logic [`LOOKUP_IDX_W-1:0] wr_index_q;
    logic [`CTRL_DATA_W-1:0]  wr_entry_q;

    // header decode
    // stage id sits in the top 5 bits of the module id
    assign hdr_mod_id     = ctrl_in.data[`HDR_MODID_LSB +: 8];
    assign hdr_sel        = ctrl_in.data[`HDR_RESV_LSB +: 4];
    assign hdr_flag       = ctrl_in.data[`HDR_FLAG_LSB +: 16];
    assign idx_load_value = ctrl_in.data[`HDR_INDEX_LSB +: `LOOKUP_IDX_W];
    assign hdr_hit = (hdr_mod_id[7:3] == STAGE_ID) && (hdr_mod_id[2:0] == LOOKUP_ID)
                     && (hdr_flag == `CTRL_FLAG);

    always_comb begin
        state_d     = state_q;
        idx_load    = 1'b0;
        idx_advance = 1'b0;
        fwd         = 1'b0;
        case (state_q)
            IDLE: begin
                if (ctrl_in.valid && hdr_hit) begin
                    // header alone carries no entries
                    if (!ctrl_in.last) begin
                        idx_load = 1'b1;
                        state_d  = (hdr_sel == 4'd0) ? KEY_ENTRY : ACT_ENTRY;
                    end
                end else if (ctrl_in.valid) begin
                    fwd = 1'b1;
                    if (!ctrl_in.last) begin
                        state_d = FORWARD;
                    end
                end
            end
            KEY_ENTRY, ACT_ENTRY: begin
                idx_advance = ctrl_in.valid;
                if (ctrl_in.valid && ctrl_in.last) begin
                    state_d = IDLE;
                end
            end
            default: begin
                fwd = ctrl_in.valid;
                if (ctrl_in.valid && ctrl_in.last) begin
                    state_d = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            out_valid_q <= 1'b0;
            key_we_q    <= 1'b0;
            act_we_q    <= 1'b0;
        end else begin
            state_q     <= state_d;
            out_valid_q <= fwd;
            key_we_q    <= idx_advance && (state_q == KEY_ENTRY);
            act_we_q    <= idx_advance && (state_q == ACT_ENTRY);
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            out_data_q <= ctrl_in.data;
            out_last_q <= ctrl_in.last;
        end
        if (idx_advance) begin
            wr_index_q <= idx;
            wr_entry_q <= ctrl_in.data;
        end
    end

    assign ctrl_out = '{data: out_data_q, last: out_last_q, valid: out_valid_q};
    assign wr = '{key_we: key_we_q, act_we: act_we_q, index: wr_index_q, entry: wr_entry_q};

    a_one_table_write : assert property (
        @(posedge clk) disable iff (!rst_n) !(wr.key_we && wr.act_we)
    ) else $error("key and action table written in the same cycle");

endmodule

/* logic/action_table.sv */
//####################
// action table
// one write port from the control path
// and a registered read port
//####################

`timescale 1ns/1ns

`include "lookup_macros.svh"

module action_table (
    input  logic                      clk,
    input  lookup_pkg::table_write_t  wr,
    input  logic                      rd_en,
    input  logic [`LOOKUP_IDX_W-1:0]  rd_index,
    output logic [`LOOKUP_ACT_W-1:0]  rd_action
);

    logic [`LOOKUP_ACT_W-1:0] act_mem [`LOOKUP_DEPTH];

    // an entry fits in the low bits of one beat
    always_ff @(posedge clk) begin
        if (wr.act_we) begin
            act_mem[wr.index] <= wr.entry[`LOOKUP_ACT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_action <= act_mem[rd_index];
        end
    end

endmodule

/* logic/key_match_table.sv */
//####################
// key match table
// 16 stored keys with valid bits
// masked compare and lowest index wins
//####################

`timescale 1ns/1ns

`include "lookup_macros.svh"

module key_match_table (
    input  logic                      clk,
    input  logic                      rst_n,
    input  lookup_pkg::table_write_t  wr,
    input  lookup_pkg::lookup_key_t   key_in,
    output logic                      match,
    output logic [`LOOKUP_IDX_W-1:0]  match_index
);

    logic [`LOOKUP_KEY_W-1:0] key_mem [`LOOKUP_DEPTH];
    logic [`LOOKUP_DEPTH-1:0] entry_valid;

    logic [`LOOKUP_KEY_W-1:0] key_q;
    logic [`LOOKUP_KEY_W-1:0] mask_q;

    logic [`LOOKUP_DEPTH-1:0] hit_vec;
    logic [`LOOKUP_IDX_W-1:0] hit_index;

    // stored keys
    always_ff @(posedge clk) begin
        if (wr.key_we) begin
            key_mem[wr.index] <= wr.entry[`LOOKUP_KEY_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (wr.key_we) begin
            entry_valid[wr.index] <= 1'b1;
        end
    end

    // request held for the compare cycle
    always_ff @(posedge clk) begin
        key_q  <= key_in.key;
        mask_q <= key_in.mask;
    end

    always_comb begin
        for (int i = 0; i < `LOOKUP_DEPTH; i++) begin
            hit_vec[i] = entry_valid[i] && (((key_mem[i] ^ key_q) & ~mask_q) == '0);
        end
    end

    // scan from the top so the lowest hit is kept
    always_comb begin
        hit_index = '0;
        for (int i = `LOOKUP_DEPTH - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_index = `LOOKUP_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match       <= 1'b0;
            match_index <= '0;
        end else begin
            match       <= |hit_vec;
            match_index <= hit_index;
        end
    end

endmodule

/* logic/entry_index_counter.sv */
//####################
// table write index
// loaded from the header
// one step per written entry
//####################

`timescale 1ns/1ns

`include "lookup_macros.svh"

module entry_index_counter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load,
    input  logic [`LOOKUP_IDX_W-1:0]  load_value,
    input  logic                      advance,
    output logic [`LOOKUP_IDX_W-1:0]  idx
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (load) begin
            idx <= load_value;
        end else if (advance) begin
            // wrap back to entry 0 after the last one
            if (idx == `LOOKUP_IDX_W'(`LOOKUP_DEPTH - 1)) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // header and entry beats never share a cycle
    a_load_advance_excl : assert property (
        @(posedge clk) disable iff (!rst_n) !(load && advance)
    ) else $error("index counter load and advance together");

endmodule

/* logic/lookup_pkg.sv */
//####################
// lookup stage shared types
// key request, result, control beat
// and table write
//####################

`include "lookup_macros.svh"

package lookup_pkg;

    // key request from the extractor
    // a mask bit of 1 means don't care
    typedef struct packed {
        logic [`LOOKUP_KEY_W-1:0] key;
        logic [`LOOKUP_KEY_W-1:0] mask;
        logic [`LOOKUP_PHV_W-1:0] phv;
    } lookup_key_t;

    // action toward the next stage
    typedef struct packed {
        logic [`LOOKUP_ACT_W-1:0] action;
        logic [`LOOKUP_PHV_W-1:0] phv;
    } lookup_result_t;

    // one control stream word
    typedef struct packed {
        logic [`CTRL_DATA_W-1:0] data;
        logic                    last;
        logic                    valid;
    } ctrl_beat_t;

    // single entry write into either table
    typedef struct packed {
        logic                    key_we;
        logic                    act_we;
        logic [`LOOKUP_IDX_W-1:0] index;
        logic [`CTRL_DATA_W-1:0] entry;
    } table_write_t;

endpackage

/* logic/lookup_macros.svh */
//####################
// lookup stage widths and table depth
// plus the control header layout
//####################

`ifndef LOOKUP_MACROS_SVH
`define LOOKUP_MACROS_SVH

// lookup path widths
`define LOOKUP_KEY_W 32
`define LOOKUP_ACT_W 48
`define LOOKUP_PHV_W 64

// both tables share depth and index width
`define LOOKUP_DEPTH 16
`define LOOKUP_IDX_W 4

// control stream
`define CTRL_DATA_W 64
`define CTRL_FLAG 16'hf2f1

// action sent when no entry matches
`define DEFAULT_ACTION 48'h3f

// header beat field positions
`define HDR_INDEX_LSB 0
`define HDR_FLAG_LSB 16
`define HDR_RESV_LSB 32
`define HDR_MODID_LSB 36

`endif
